// File: single_cpu.f
+incdir+.
single_cpu_pkg.sv
inst_mem.sv
reg_file.sv
inst_decode.sv
alu.sv
data_mem.sv
single_cpu.sv
tb_clock.sv
single_cpu_props.sv
single_cpu_tb.sv

// File: single_cpu_tb.sv
`include "single_cpu_params.svh"

module single_cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import single_cpu_pkg::*;

    localparam int LOAD_BASE   = 16;    // Program words start here, ahead of the pc
    localparam int CYCLE_LIMIT = 2000;  // Six tests under 60 cycles each, wide margin

    logic        CLK;
    logic        RST;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata;
    wb_trace_t   trace;

    logic [31:0] ref_regs [32];
    logic [31:0] ref_dmem [`DMEM_DEPTH];
    logic [31:0] ref_imem [`IMEM_DEPTH];
    logic [31:0] ref_pc;
    logic [31:0] program_words [$];
    logic [31:0] lcg_state = 32'he5d8a38e;
    int          cycle_count = 0;

    tb_clock tb_clock_inst (
        .CLK (CLK)
    );

    single_cpu single_cpu_inst (
        .CLK        (CLK),
        .RST        (RST),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .trace      (trace)
    );

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [11:0] random_imm();
        logic [31:0] v;
        v = next_random();
        return v[23:12];  // Upper bits mix better
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    // RV32I result for one funct3, alt picks sub or sra
    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s %s: expected %h, actual %h", test, field, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Predicts the trace of the instruction at ref_pc, then applies its effect
    task automatic retire_and_check(input string test);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] addr;
        logic [31:0] result;
        logic        writes;
        logic        stores;
        logic [4:0]  exp_rd;
        w      = ref_imem[ref_pc[7:2]];
        f3     = w[14:12];
        f7     = w[31:25];
        a      = ref_regs[w[19:15]];
        addr   = a + {{20{w[31]}}, w[31:20]};
        result = 32'h0;
        writes = 1'b0;
        stores = 1'b0;
        case (w[6:0])
            OP_R: begin
                result = expected_alu(f3, w[30], a, ref_regs[w[24:20]]);
                writes = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            OP_I_ALU: begin
                result = expected_alu(f3, f3 == 3'd5 && w[30], a, {{20{w[31]}}, w[31:20]});
                writes = (f3 == 3'd1) ? (f7 == 7'h00)
                       : (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            end
            OP_LOAD: begin
                result = ref_dmem[addr[7:2]];
                writes = (f3 == 3'd2);
            end
            OP_STORE: begin
                addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};
                stores = (f3 == 3'd2);
            end
            default: ;  // Unknown opcode changes nothing
        endcase
        exp_rd = writes ? w[11:7] : 5'd0;
        check_value(test, "valid", 32'd1, 32'(trace.valid));
        check_value(test, "pc", ref_pc, trace.pc);
        check_value(test, "rd", 32'(exp_rd), 32'(trace.rd));
        check_value(test, "data", (exp_rd != 5'd0) ? result : 32'h0, trace.data);
        if (exp_rd != 5'd0) ref_regs[exp_rd] = result;
        if (stores) ref_dmem[addr[7:2]] = ref_regs[w[24:20]];
        ref_pc = (ref_pc + 32'd4) % (`IMEM_DEPTH * 4);
    endtask

    task automatic reset_core(input string test);
        @(posedge CLK);
        #1;
        RST     = 1'b1;
        imem_we = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            @(posedge CLK);
            #1;
            if (k == 4) RST = 1'b0;  // Released after four reset edges
            #1;
            check_value(test, "valid in reset", 32'd0, 32'(trace.valid));
        end
        for (int i = 0; i < 32; i++) ref_regs[i] = 32'h0;
        for (int i = 0; i < `DMEM_DEPTH; i++) ref_dmem[i] = 32'h0;
        for (int i = 0; i < `IMEM_DEPTH; i++) ref_imem[i] = 32'h0;
        ref_pc = `RESET_PC;
    endtask

    // Imem is cleared on every reset edge, so the program is written after
    // release while the pc walks through zero words behind it
    task automatic run_program(input string test);
        int n;
        int cycles;
        n      = program_words.size();
        cycles = LOAD_BASE + n + 2;
        reset_core(test);
        for (int i = 0; i < cycles; i++) begin
            @(posedge CLK);
            #1;
            imem_we = (i < n);
            if (i < n) begin
                imem_addr  = 6'(LOAD_BASE + i);
                imem_wdata = program_words[i];
            end
            #1;
            retire_and_check(test);
            if (i < n) ref_imem[LOAD_BASE + i] = program_words[i];  // Lands at next edge
        end
        program_words.delete();
    endtask

    task automatic reset_and_fetch();
        for (int k = 0; k < 4; k++) begin
            program_words.push_back(i_type_word(random_imm(), 5'(k), 3'd0, 5'(k + 1), OP_I_ALU));
        end
        run_program("reset_and_fetch");
    endtask

    task automatic imm_alu_ops();
        for (int round = 0; round < 2; round++) begin
            program_words.push_back(i_type_word(random_imm(), 5'd0, 3'd0, 5'd1, OP_I_ALU));
            for (int f = 0; f < 8; f++) begin
                if (f != 1 && f != 5) begin  // Shifts have their own test
                    program_words.push_back(i_type_word(random_imm(), 5'd1, 3'(f),
                                                        5'(f + 8), OP_I_ALU));
                end
            end
        end
        run_program("imm_alu_ops");
    endtask

    task automatic reg_alu_ops();
        for (int round = 0; round < 2; round++) begin
            program_words.push_back(i_type_word(random_imm(), 5'd0, 3'd0, 5'd1, OP_I_ALU));
            program_words.push_back(i_type_word(12'd19, 5'd1, 3'd1, 5'd1, OP_I_ALU));
            program_words.push_back(i_type_word(random_imm(), 5'd1, 3'd4, 5'd1, OP_I_ALU));
            // Bit 5 set, so the shift amount is above 31
            program_words.push_back(i_type_word(random_imm() | 12'h020, 5'd0, 3'd0, 5'd2,
                                                OP_I_ALU));
            for (int f = 0; f < 8; f++) begin
                program_words.push_back(r_type_word(7'h00, 5'd2, 5'd1, 3'(f), 5'(f + 3)));
            end
            program_words.push_back(r_type_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd16));
            program_words.push_back(r_type_word(7'h20, 5'd2, 5'd1, 3'd5, 5'd17));
            program_words.push_back(r_type_word(7'h00, 5'd1, 5'd2, 3'd2, 5'd18));
            program_words.push_back(r_type_word(7'h00, 5'd1, 5'd2, 3'd3, 5'd19));
        end
        run_program("reg_alu_ops");
    endtask

    task automatic shift_imm_ops();
        logic [4:0] sh;
        for (int round = 0; round < 3; round++) begin
            sh = 5'(random_imm());
            program_words.push_back(i_type_word(random_imm(), 5'd0, 3'd0, 5'd1, OP_I_ALU));
            program_words.push_back(i_type_word({7'h00, sh}, 5'd1, 3'd1, 5'd2, OP_I_ALU));
            program_words.push_back(i_type_word({7'h00, sh}, 5'd1, 3'd5, 5'd3, OP_I_ALU));
            program_words.push_back(i_type_word({7'h20, sh}, 5'd1, 3'd5, 5'd4, OP_I_ALU));
        end
        run_program("shift_imm_ops");
    endtask

    task automatic load_store();
        program_words.push_back(i_type_word({4'b0, 6'(random_imm()), 2'b00}, 5'd0, 3'd0,
                                            5'd1, OP_I_ALU));
        program_words.push_back(i_type_word(random_imm(), 5'd0, 3'd0, 5'd2, OP_I_ALU));
        program_words.push_back(i_type_word(random_imm(), 5'd0, 3'd0, 5'd3, OP_I_ALU));
        program_words.push_back(store_word(12'd0, 5'd2, 5'd1));
        program_words.push_back(store_word(12'd8, 5'd3, 5'd1));
        program_words.push_back(i_type_word(12'd0, 5'd1, 3'd2, 5'd4, OP_LOAD));
        program_words.push_back(i_type_word(12'd8, 5'd1, 3'd2, 5'd5, OP_LOAD));
        program_words.push_back(i_type_word(12'd4, 5'd1, 3'd2, 5'd6, OP_LOAD));  // Never written
        program_words.push_back(store_word(12'hffc, 5'd3, 5'd1));
        program_words.push_back(i_type_word(12'hffc, 5'd1, 3'd2, 5'd7, OP_LOAD));
        program_words.push_back(i_type_word(12'd0, 5'd1, 3'd2, 5'd8, OP_LOAD));
        run_program("load_store");
    endtask

    task automatic zero_reg_and_nop();
        logic [31:0] junk;
        junk = next_random();
        program_words.push_back(i_type_word(random_imm(), 5'd0, 3'd0, 5'd1, OP_I_ALU));
        program_words.push_back(i_type_word(random_imm(), 5'd1, 3'd0, 5'd0, OP_I_ALU));
        program_words.push_back(r_type_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd2));
        program_words.push_back({junk[31:7], 7'b1111111});   // Unknown opcode
        program_words.push_back({junk[24:0], 7'b1100011});   // Branch, not supported
        program_words.push_back(r_type_word(7'h01, 5'd1, 5'd1, 3'd0, 5'd5));  // Bad funct7
        program_words.push_back(r_type_word(7'h00, 5'd0, 5'd1, 3'd6, 5'd3));
        program_words.push_back(r_type_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd0));
        program_words.push_back(r_type_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd4));
        program_words.push_back(r_type_word(7'h00, 5'd0, 5'd5, 3'd0, 5'd6));
        run_program("zero_reg_and_nop");
    endtask

    initial begin
        RST        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = 6'd0;
        imem_wdata = 32'h0;
        reset_and_fetch();
        imm_alu_ops();
        reg_alu_ops();
        shift_imm_ops();
        load_store();
        zero_reg_and_nop();
        $display("No errors");
        $finish;
    end

endmodule

// File: single_cpu_props.sv
`include "single_cpu_params.svh"

module single_cpu_props (
    input logic        CLK,
    input logic        RST,
    input logic        valid,
    input logic [31:0] pc,
    input logic [4:0]  rs1,
    input logic [4:0]  rs2,
    input logic [31:0] rd1,
    input logic [31:0] rd2
);

    timeunit 1ns;
    timeprecision 100ps;

    x0_port1_zero: assert property (@(posedge CLK) rs1 == 5'd0 |-> rd1 == 32'h0)
        else $error("x0 read on port 1 returned %h", rd1);

    x0_port2_zero: assert property (@(posedge CLK) rs2 == 5'd0 |-> rd2 == 32'h0)
        else $error("x0 read on port 2 returned %h", rd2);

    // valid_q is cleared by the edge that samples RST
    valid_low_in_reset: assert property (@(posedge CLK) RST |=> !valid)
        else $error("trace valid is high after a reset cycle");

    pc_steps_by_four: assert property (@(posedge CLK) disable iff (RST)
        valid && $past(valid) |-> pc == 32'(($past(pc) + 32'd4) % (`IMEM_DEPTH * 4)))
        else $error("pc moved from %h to %h", $past(pc), pc);

endmodule

bind single_cpu single_cpu_props single_cpu_props_inst (
    .CLK   (CLK),
    .RST   (RST),
    .valid (trace.valid),
    .pc    (pc),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd1   (rd1),
    .rd2   (rd2)
);

// File: tb_clock.sv
module tb_clock (
    output logic CLK
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
    end

    always #5 CLK = ~CLK;  // 10 ns period

endmodule

// File: single_cpu.sv
`include "single_cpu_params.svh"

module single_cpu (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      imem_we,
    input  logic [5:0]                imem_addr,
    input  logic [31:0]               imem_wdata,
    output single_cpu_pkg::wb_trace_t trace
);

    import single_cpu_pkg::*;

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic        valid_q;     // High once the core is retiring
    inst_u       inst;
    ctrl_t       ctrl;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        reg_we;
    logic        mem_we;

    // Wrap within the instruction memory
    assign pc_next = 32'((pc + 32'd4) % (`IMEM_DEPTH * 4));

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc      <= `RESET_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            if (valid_q) begin
                pc <= pc_next;  // First cycle out of reset holds RESET_PC
            end
        end
    end

    inst_mem inst_mem_inst (
        .CLK   (CLK),
        .RST   (RST),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (pc[7:2]),
        .inst  (inst)
    );

    inst_decode inst_decode_inst (
        .inst (inst),
        .ctrl (ctrl),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm)
    );

    assign reg_we = ctrl.reg_we & valid_q;  // No state change before first retire
    assign mem_we = ctrl.mem_we & valid_q;

    reg_file reg_file_inst (
        .CLK (CLK),
        .RST (RST),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd  (rd),
        .we  (reg_we),
        .wd  (wb_data),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign alu_b = ctrl.use_imm ? imm : rd2;

    alu alu_inst (
        .op (ctrl.alu_op),
        .a  (rd1),
        .b  (alu_b),
        .y  (alu_y)
    );

    data_mem data_mem_inst (
        .CLK  (CLK),
        .RST  (RST),
        .we   (mem_we),
        .addr (alu_y[7:2]),  // Word index of byte address
        .wd   (rd2),
        .rd   (load_data)
    );

    assign wb_data = ctrl.mem_to_reg ? load_data : alu_y;

    // rd is already zero when nothing is written
    assign trace = '{
        valid: valid_q,
        pc:    pc,
        rd:    rd,
        data:  (rd != 5'd0) ? wb_data : 32'h0
    };

endmodule

// File: data_mem.sv
`include "single_cpu_params.svh"

module data_mem (
    input  logic        CLK,
    input  logic        RST,
    input  logic        we,
    input  logic [5:0]  addr,
    input  logic [31:0] wd,
    output logic [31:0] rd
);

    logic [31:0] mem [`DMEM_DEPTH];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= 32'h0;  // Unwritten words read as zero
            end
        end else if (we) begin
            mem[addr] <= wd;
        end
    end

    assign rd = mem[addr];  // Asynchronous read

endmodule

// File: alu.sv
module alu (
    input  single_cpu_pkg::alu_op_e op,
    input  logic [31:0]             a,
    input  logic [31:0]             b,
    output logic [31:0]             y
);

    import single_cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Upper bits ignored

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SLT: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                y = {31'b0, a < b};
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SRL: begin
                y = a >> shamt;
            end
            ALU_SRA: begin
                y = $signed(a) >>> shamt;  // Sign bit fills
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_AND: begin
                y = a & b;
            end
            default: begin
                y = 32'h0;
            end
        endcase
    end

endmodule

// File: inst_decode.sv
module inst_decode (
    input  single_cpu_pkg::inst_u inst,
    output single_cpu_pkg::ctrl_t ctrl,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [31:0]           imm
);

    import single_cpu_pkg::*;

    alu_op_e    op;
    logic       legal;      // funct3/funct7 pair is supported
    logic       imm_form;   // I-type ALU, funct7 is imm[11:5]
    logic [2:0] f3;
    logic [6:0] f7;

    assign f3       = inst.r_fmt.funct3;
    assign f7       = inst.r_fmt.funct7;
    assign imm_form = (inst.r_fmt.opcode == OP_I_ALU);

    // ALU operation shared by R-type and I-type ALU forms
    always_comb begin
        op    = ALU_ADD;
        legal = 1'b1;
        case (f3)
            F3_ADD_SUB: begin
                if (imm_form || f7 == F7_BASE) begin
                    op = ALU_ADD;
                end else if (f7 == F7_ALT) begin
                    op = ALU_SUB;
                end else begin
                    legal = 1'b0;
                end
            end
            F3_SLL: begin
                op    = ALU_SLL;
                legal = (f7 == F7_BASE);  // slli checks it too
            end
            F3_SLT: begin
                op    = ALU_SLT;
                legal = imm_form || f7 == F7_BASE;
            end
            F3_SLTU: begin
                op    = ALU_SLTU;
                legal = imm_form || f7 == F7_BASE;
            end
            F3_XOR: begin
                op    = ALU_XOR;
                legal = imm_form || f7 == F7_BASE;
            end
            F3_SRL_SRA: begin
                if (f7 == F7_BASE) begin
                    op = ALU_SRL;
                end else if (f7 == F7_ALT) begin
                    op = ALU_SRA;
                end else begin
                    legal = 1'b0;
                end
            end
            F3_OR: begin
                op    = ALU_OR;
                legal = imm_form || f7 == F7_BASE;
            end
            F3_AND: begin
                op    = ALU_AND;
                legal = imm_form || f7 == F7_BASE;
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm         = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        case (inst.r_fmt.opcode)
            OP_R: begin
                ctrl.alu_op = op;
                ctrl.reg_we = legal;
            end
            OP_I_ALU: begin
                ctrl.alu_op  = op;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = legal;
            end
            OP_LOAD: begin
                ctrl.use_imm    = 1'b1;
                ctrl.reg_we     = (inst.i_fmt.funct3 == F3_WORD);
                ctrl.mem_to_reg = 1'b1;
            end
            OP_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = (inst.s_fmt.funct3 == F3_WORD);
                imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            end
            default: ;  // Unknown opcode retires as no-op
        endcase
    end

    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;
    assign rd  = ctrl.reg_we ? inst.i_fmt.rd : 5'd0;

endmodule

// File: reg_file.sv
module reg_file (
    input  logic        CLK,
    input  logic        RST,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && rd != 5'd0) begin  // Drop writes to x0
            regs[rd] <= wd;
        end
    end

    always_comb begin
        rd1 = 32'h0;
        rd2 = 32'h0;
        if (rs1 != 5'd0) begin
            rd1 = regs[rs1];
        end
        if (rs2 != 5'd0) begin
            rd2 = regs[rs2];
        end
    end

endmodule

// File: inst_mem.sv
`include "single_cpu_params.svh"

module inst_mem (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 we,
    input  logic [5:0]           waddr,
    input  logic [31:0]          wdata,
    input  logic [5:0]           raddr,
    output single_cpu_pkg::inst_u inst
);

    logic [31:0] mem [`IMEM_DEPTH];

    // Load port has priority over the clear so a program
    // can be written while reset is held
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `IMEM_DEPTH; i++) begin
                mem[i] <= 32'h0;  // Zero word is a no-op
            end
        end
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign inst = mem[raddr];  // Combinational fetch

endmodule

// File: single_cpu_pkg.sv
package single_cpu_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_I_ALU = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;  // lw / sw width

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, three field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;     // Immediate as operand b
        logic    reg_we;
        logic    mem_we;
        logic    mem_to_reg;  // Load data to rd
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_trace_t;

endpackage

// File: single_cpu_params.svh
`ifndef SINGLE_CPU_PARAMS_SVH
`define SINGLE_CPU_PARAMS_SVH

// Instruction memory size in 32-bit words
`define IMEM_DEPTH 64

// Data memory size in 32-bit words
`define DMEM_DEPTH 64

// Byte address fetched first after reset
`define RESET_PC 32'h0000_0000

`endif
